// File: rtl/response_router_config.svh
`ifndef RESPONSE_ROUTER_CONFIG_SVH
`define RESPONSE_ROUTER_CONFIG_SVH

// ------------------------------------------------------------------------
// Receiver fan-out, also the width of the destination mask
// ------------------------------------------------------------------------
`define RR_NUM_RECEIVERS 4

// Payload field widths
`define RR_CMD_WIDTH 8
`define RR_DATA_WIDTH 32

// ------------------------------------------------------------------------
// Response queue sizing
// ------------------------------------------------------------------------
// Depth must be a power of two, pointers wrap on their own
`define RR_QUEUE_DEPTH 16

// Occupancy at or above this raises prog_full
`define RR_PROG_THRESH 8

`endif

// File: rtl/response_router_pkg.sv
`include "response_router_config.svh"

package response_router_pkg;

  // ----------------------------------------------------------------------
  // Destination masks and receiver ready levels
  // ----------------------------------------------------------------------
  typedef logic [`RR_NUM_RECEIVERS-1:0] receiver_mask_t;

  // ----------------------------------------------------------------------
  // Control response, 44 bits of payload
  // ----------------------------------------------------------------------
  typedef struct packed {
    receiver_mask_t            dest;
    logic [`RR_CMD_WIDTH-1:0]  cmd;
    logic [`RR_DATA_WIDTH-1:0] data;
  } control_payload_t;

  // Payload plus its strobe
  typedef struct packed {
    logic             valid;
    control_payload_t payload;
  } control_packet_t;

  // ----------------------------------------------------------------------
  // Queue status levels
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic full;
    logic empty;
    logic prog_full;
  } queue_status_t;

endpackage : response_router_pkg

// File: rtl/response_queue.sv
`timescale 1ns/10ps

`include "response_router_config.svh"

module response_queue (
  input  logic                             ap_clk,
  input  logic                             areset_control,
  input  response_router_pkg::control_packet_t response_in,
  input  logic                             pop,
  output response_router_pkg::control_packet_t head,
  output response_router_pkg::queue_status_t   queue_status
);

  import response_router_pkg::*;

  localparam int PTR_W = $clog2(`RR_QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // ------------------------------------------------------------------------
  // Input register and filter stage
  // ------------------------------------------------------------------------
  logic             in_valid_reg;
  control_payload_t in_payload_reg;
  logic             wr_valid_reg;
  control_payload_t wr_payload_reg;

  // ------------------------------------------------------------------------
  // Circular buffer
  // ------------------------------------------------------------------------
  control_payload_t mem [`RR_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             at_full;
  logic             at_empty;
  logic             wr_en;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= 1'b0;
    end else begin
      in_valid_reg <= response_in.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_payload_reg <= response_in.payload;
  end

  // Responses with no destination never reach the buffer
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_valid_reg <= 1'b0;
    end else begin
      wr_valid_reg <= in_valid_reg & (|in_payload_reg.dest);
    end
  end

  always_ff @(posedge ap_clk) begin
    wr_payload_reg <= in_payload_reg;
  end

  assign at_full  = (count == CNT_W'(`RR_QUEUE_DEPTH));
  assign at_empty = (count == '0);

  // Arrivals while full are lost
  assign wr_en = wr_valid_reg & ~at_full;

  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_payload_reg;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      count <= '0;
    end else begin
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // First-word-fall-through head
  // ------------------------------------------------------------------------
  // Valid follows occupancy directly so a pop can follow the write
  assign head.valid   = ~at_empty;
  assign head.payload = mem[rd_ptr];

  // Status lags occupancy by one cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      queue_status.full      <= 1'b0;
      queue_status.empty     <= 1'b1;
      queue_status.prog_full <= 1'b0;
    end else begin
      queue_status.full      <= at_full;
      queue_status.empty     <= at_empty;
      queue_status.prog_full <= (count >= CNT_W'(`RR_PROG_THRESH));
    end
  end

  // ------------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------------
  // The tracker only pops a stored response
  a_no_pop_when_empty : assert property (
    @(posedge ap_clk) disable iff (areset_control)
    pop |-> !at_empty
  ) else $error("pop while queue empty");

  a_count_in_range : assert property (
    @(posedge ap_clk) disable iff (areset_control)
    count <= CNT_W'(`RR_QUEUE_DEPTH)
  ) else $error("queue occupancy above depth");

endmodule : response_queue

// File: rtl/receiver_ack_tracker.sv
`timescale 1ns/10ps

`include "response_router_config.svh"

module receiver_ack_tracker (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  response_router_pkg::receiver_mask_t  receiver_ready,
  input  response_router_pkg::control_packet_t head,
  output logic                                 pop
);

  import response_router_pkg::*;

  // ------------------------------------------------------------------------
  // Registered ready levels
  // ------------------------------------------------------------------------
  receiver_mask_t ready_reg;
  receiver_mask_t ready_masked;
  logic           all_ready;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_reg <= '0;
    end else begin
      ready_reg <= receiver_ready;
    end
  end

  // Only receivers named by the head count
  always_comb begin
    for (int i = 0; i < `RR_NUM_RECEIVERS; i++) begin
      ready_masked[i] = ready_reg[i] & head.payload.dest[i];
    end
  end

  assign all_ready = (ready_masked == head.payload.dest);

  // ------------------------------------------------------------------------
  // Pop decision
  // ------------------------------------------------------------------------
  // Head leaves only once every addressed receiver is ready
  assign pop = head.valid & all_ready;

  // Zero-mask responses are filtered before storage
  a_pop_has_dest : assert property (
    @(posedge ap_clk) disable iff (areset_control)
    pop |-> (|head.payload.dest)
  ) else $error("pop of a response without destination");

endmodule : receiver_ack_tracker

// File: rtl/response_demux.sv
`timescale 1ns/10ps

`include "response_router_config.svh"

module response_demux (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  response_router_pkg::control_packet_t head,
  input  logic                                 pop,
  output response_router_pkg::control_packet_t response_out [`RR_NUM_RECEIVERS-1:0]
);

  import response_router_pkg::*;

  // ------------------------------------------------------------------------
  // Staging register, sampled on pop
  // ------------------------------------------------------------------------
  logic             stage_valid;
  control_payload_t stage_payload;

  // Output register
  receiver_mask_t   out_valid;
  control_payload_t out_payload;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= pop;
    end
  end

  always_ff @(posedge ap_clk) begin
    stage_payload <= head.payload;
  end

  // ------------------------------------------------------------------------
  // Per-receiver valid, broadcast payload
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= '0;
    end else begin
      for (int i = 0; i < `RR_NUM_RECEIVERS; i++) begin
        out_valid[i] <= stage_valid & stage_payload.dest[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    out_payload <= stage_payload;
  end

  for (genvar i = 0; i < `RR_NUM_RECEIVERS; i++) begin : gen_out
    assign response_out[i].valid   = out_valid[i];
    assign response_out[i].payload = out_payload;
  end

  // Every delivery traces back to a staged pop, and every staged pop reaches a receiver
  a_out_from_stage : assert property (
    @(posedge ap_clk) disable iff (areset_control)
    (|out_valid) == $past(stage_valid)
  ) else $error("response_out valid does not match staged response");

endmodule : response_demux

// File: rtl/response_router.sv
`timescale 1ns/10ps

`include "response_router_config.svh"

module response_router (
  input  logic                                 ap_clk,
  input  logic                                 areset_control,
  input  response_router_pkg::control_packet_t response_in,
  input  response_router_pkg::receiver_mask_t  receiver_ready,
  output response_router_pkg::control_packet_t response_out [`RR_NUM_RECEIVERS-1:0],
  output response_router_pkg::queue_status_t   queue_status
);

  import response_router_pkg::*;

  // ------------------------------------------------------------------------
  // Queue head and pop strobe
  // ------------------------------------------------------------------------
  control_packet_t head;
  logic            pop;

  // Input register, filter and FWFT storage
  response_queue u_response_queue (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .response_in    (response_in),
    .pop            (pop),
    .head           (head),
    .queue_status   (queue_status)
  );

  // Waits for all addressed receivers
  receiver_ack_tracker u_receiver_ack_tracker (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .receiver_ready (receiver_ready),
    .head           (head),
    .pop            (pop)
  );

  // Two-stage fan-out to the receivers
  response_demux u_response_demux (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .head           (head),
    .pop            (pop),
    .response_out   (response_out)
  );

endmodule : response_router

// File: bench/tb_response_checks.svh
`ifndef TB_RESPONSE_CHECKS_SVH
`define TB_RESPONSE_CHECKS_SVH

// ------------------------------------------------------------------------
// Compare tasks, one per kind of DUT result
// ------------------------------------------------------------------------

// One delivered packet, valid bit and payload together
task automatic check_packet(input string name, input control_packet_t got,
                            input control_packet_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    abort_run();
  end
endtask

// Registered queue status levels
task automatic check_status(input string name, input queue_status_t got,
                            input queue_status_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    abort_run();
  end
endtask

// Per-receiver valid bits gathered into a mask
task automatic check_mask(input string name, input receiver_mask_t got,
                          input receiver_mask_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    abort_run();
  end
endtask

`endif

// File: bench/tb_response_router.sv
`timescale 1ns/10ps

`include "response_router_config.svh"

module tb_response_router;

  import response_router_pkg::*;

  localparam int NUM_STEPS   = 39;
  localparam int SETTLE      = 6;
  localparam int DRAIN_LIMIT = 200;
  localparam int SEED        = 32'h8316_af32;

  // One table row: response fields, ready levels, idle cycles afterwards
  typedef struct packed {
    receiver_mask_t            dest;
    logic [`RR_CMD_WIDTH-1:0]  cmd;
    logic [`RR_DATA_WIDTH-1:0] data;
    receiver_mask_t            ready;
    logic [7:0]                hold;
  } step_t;

  // ------------------------------------------------------------------------
  // Stimulus table, a zero data word is replaced by a random one
  // ------------------------------------------------------------------------
  localparam step_t STEPS [NUM_STEPS] = '{
    // Single destinations, all ready
    '{4'b0001, 8'h21, 32'hcafe_0001, 4'b1111, 8'd6},
    '{4'b0010, 8'h22, 32'h0000_0000, 4'b1111, 8'd6},
    '{4'b0100, 8'h23, 32'h0000_0000, 4'b1111, 8'd6},
    '{4'b1000, 8'h24, 32'hdead_beef, 4'b1111, 8'd6},
    '{4'b0001, 8'h25, 32'h0000_0000, 4'b1111, 8'd0},
    '{4'b0001, 8'h26, 32'h0000_0000, 4'b1111, 8'd8},
    // Multi-bit destinations
    '{4'b0101, 8'h31, 32'h0000_0000, 4'b1111, 8'd6},
    '{4'b1110, 8'h32, 32'h0000_0000, 4'b1111, 8'd6},
    '{4'b1111, 8'h33, 32'h0f0f_0f0f, 4'b1111, 8'd6},
    // Zero destinations mixed in
    '{4'b0000, 8'h41, 32'h4444_4444, 4'b1111, 8'd6},
    '{4'b0100, 8'h42, 32'h0000_0000, 4'b1111, 8'd0},
    '{4'b0000, 8'h43, 32'h0000_0000, 4'b1111, 8'd0},
    '{4'b0100, 8'h44, 32'h0000_0000, 4'b1111, 8'd8},
    // Fill with nobody ready, then release
    '{4'b0001, 8'h51, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0010, 8'h52, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0100, 8'h53, 32'h0000_0000, 4'b0000, 8'd0},
    // Zero mask takes no slot
    '{4'b0000, 8'h50, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b1000, 8'h54, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0011, 8'h55, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b1100, 8'h56, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0001, 8'h57, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b1111, 8'h58, 32'h0000_0000, 4'b0000, 8'd6},
    '{4'b0010, 8'h59, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0100, 8'h5a, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b1000, 8'h5b, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0001, 8'h5c, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0110, 8'h5d, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b1001, 8'h5e, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0010, 8'h5f, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0100, 8'h60, 32'h0000_0000, 4'b0000, 8'd6},
    '{4'b0001, 8'h61, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0010, 8'h62, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b0100, 8'h63, 32'h0000_0000, 4'b0000, 8'd0},
    '{4'b1000, 8'h64, 32'h0000_0000, 4'b0000, 8'd6},
    '{4'b0000, 8'h6f, 32'h0000_0000, 4'b1111, 8'd30},
    // Receiver 1 stalls the head
    '{4'b0010, 8'h71, 32'h0000_0000, 4'b1101, 8'd6},
    '{4'b0100, 8'h72, 32'h0000_0000, 4'b1101, 8'd6},
    '{4'b1001, 8'h73, 32'h0000_0000, 4'b1101, 8'd6},
    '{4'b0001, 8'h74, 32'h0000_0000, 4'b1111, 8'd12}
  };

  logic            ap_clk;
  logic            areset_control;
  control_packet_t response_in;
  receiver_mask_t  receiver_ready;
  control_packet_t response_out [`RR_NUM_RECEIVERS-1:0];
  queue_status_t   queue_status;

  // Reference model state
  control_packet_t exp_q [`RR_NUM_RECEIVERS][$];
  int              seq_q [`RR_NUM_RECEIVERS][$];
  int              occupancy;
  int              next_seq;
  int              last_seq;

  response_router u_response_router (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .response_in    (response_in),
    .receiver_ready (receiver_ready),
    .response_out   (response_out),
    .queue_status   (queue_status)
  );

  initial begin
    ap_clk = 1'b0;
  end

  always begin
    #50 ap_clk = ~ap_clk;
  end

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  `include "tb_response_checks.svh"

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  task automatic model_push(input control_payload_t p);
    control_packet_t pkt;
    pkt.valid   = 1'b1;
    pkt.payload = p;
    // Zero masks vanish, a full queue drops the arrival
    if ((|p.dest) && occupancy < `RR_QUEUE_DEPTH) begin
      for (int i = 0; i < `RR_NUM_RECEIVERS; i++) begin
        if (p.dest[i]) begin
          exp_q[i].push_back(pkt);
          seq_q[i].push_back(next_seq);
        end
      end
      next_seq++;
      occupancy++;
    end
  endtask

  function automatic queue_status_t model_status();
    queue_status_t s;
    s.full      = (occupancy == `RR_QUEUE_DEPTH);
    s.empty     = (occupancy == 0);
    s.prog_full = (occupancy >= `RR_PROG_THRESH);
    return s;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < `RR_NUM_RECEIVERS; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge ap_clk) begin : monitor
    control_packet_t exp_pkt;
    int              exp_seq;
    int              cycle_seq;
    bit              got_any;
    got_any   = 1'b0;
    cycle_seq = -1;
    if (!areset_control) begin
      for (int i = 0; i < `RR_NUM_RECEIVERS; i++) begin
        if (response_out[i].valid) begin
          if (exp_q[i].size() == 0) begin
            $display("Unexpected response delivered at receiver %0d", i);
            abort_run();
          end
          exp_pkt = exp_q[i].pop_front();
          exp_seq = seq_q[i].pop_front();
          check_packet($sformatf("response_out[%0d]", i), response_out[i], exp_pkt);
          if (got_any && exp_seq != cycle_seq) begin
            $display("Two responses delivered in the same cycle");
            abort_run();
          end
          if (!got_any && exp_seq <= last_seq) begin
            $display("Response delivered out of arrival order");
            abort_run();
          end
          got_any   = 1'b1;
          cycle_seq = exp_seq;
        end
      end
      if (got_any) begin
        last_seq = cycle_seq;
        occupancy--;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  // Entered 1 ns after a rising edge
  task automatic apply_step(input step_t s);
    control_payload_t p;
    p.dest = s.dest;
    p.cmd  = s.cmd;
    if (s.data == '0) begin
      p.data = $urandom();
    end else begin
      p.data = s.data;
    end
    receiver_ready      = s.ready;
    response_in.valid   = 1'b1;
    response_in.payload = p;
    model_push(p);
    @(posedge ap_clk);
    #1;
    response_in.valid = 1'b0;
    repeat (s.hold) begin
      @(posedge ap_clk);
      #1;
    end
    if (s.hold >= SETTLE) begin
      check_status("queue_status", queue_status, model_status());
    end
  endtask

  initial begin
    receiver_mask_t out_valids;
    int             waited;
    void'($urandom(SEED));
    occupancy      = 0;
    next_seq       = 0;
    last_seq       = -1;
    areset_control = 1'b1;
    response_in    = '0;
    receiver_ready = '0;
    repeat (10) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
    @(posedge ap_clk);
    #1;

    // Idle outputs straight after reset
    for (int i = 0; i < `RR_NUM_RECEIVERS; i++) begin
      out_valids[i] = response_out[i].valid;
    end
    check_mask("response_out valid", out_valids, '0);
    check_status("queue_status", queue_status, model_status());

    for (int n = 0; n < NUM_STEPS; n++) begin
      apply_step(STEPS[n]);
    end

    // Drain whatever is left
    receiver_ready = '1;
    waited         = 0;
    while (pending_count() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge ap_clk);
      #1;
      waited++;
    end
    repeat (2) begin
      @(posedge ap_clk);
      #1;
    end

    if (pending_count() == 0) begin
      check_status("queue_status", queue_status, model_status());
      $display("Test OK");
      $finish;
    end else begin
      $display("Timeout while waiting for %0d expected responses", pending_count());
      abort_run();
    end
  end

endmodule : tb_response_router

// File: filelist.f
+incdir+rtl
+incdir+bench
rtl/response_router_pkg.sv
rtl/response_queue.sv
rtl/receiver_ack_tracker.sv
rtl/response_demux.sv
rtl/response_router.sv
bench/tb_response_router.sv
